//--- Makefile
# Verilator build and run of the 10GBASE-R receive decoder testbench

TOP             ?= tb_baser_rx_dec
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert -j 0

# Sources come from the file list, headers are tracked as well
SRCS := $(shell grep -v '^+' files.f) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) files.f
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+include
rtl/baser_pkg.sv
rtl/ctrl_code_decoder.sv
rtl/block_mapper.sv
rtl/frame_tracker.sv
rtl/baser_rx_dec.sv
tests/baser_rx_dec_checker.sv
tests/tb_baser_rx_dec.sv

//--- rtl/baser_pkg.sv
package baser_pkg;

    // Widths
    localparam int BLOCK_W = 64;
    localparam int LANES   = 8;
    localparam int HDR_W   = 2;
    localparam int CODE_W  = 7;

    // Sync headers
    localparam logic [HDR_W-1:0] SYNC_DATA = 2'b10;
    localparam logic [HDR_W-1:0] SYNC_CTRL = 2'b01;

    // Block type field, low byte of a control block payload
    localparam logic [7:0] BT_CTRL    = 8'h1e;
    localparam logic [7:0] BT_START_0 = 8'h78;
    localparam logic [7:0] BT_START_4 = 8'h33;
    localparam logic [7:0] BT_TERM_0  = 8'h87;
    localparam logic [7:0] BT_TERM_1  = 8'h99;
    localparam logic [7:0] BT_TERM_2  = 8'haa;
    localparam logic [7:0] BT_TERM_3  = 8'hb4;
    localparam logic [7:0] BT_TERM_4  = 8'hcc;
    localparam logic [7:0] BT_TERM_5  = 8'hd2;
    localparam logic [7:0] BT_TERM_6  = 8'he1;
    localparam logic [7:0] BT_TERM_7  = 8'hff;

    // 7-bit control codes carried in control lanes
    localparam logic [CODE_W-1:0] CODE_IDLE  = 7'h00;
    localparam logic [CODE_W-1:0] CODE_LPI   = 7'h06;
    localparam logic [CODE_W-1:0] CODE_ERROR = 7'h1e;
    localparam logic [CODE_W-1:0] CODE_RES_0 = 7'h2d;
    localparam logic [CODE_W-1:0] CODE_RES_1 = 7'h33;
    localparam logic [CODE_W-1:0] CODE_RES_2 = 7'h4b;
    localparam logic [CODE_W-1:0] CODE_RES_3 = 7'h55;
    localparam logic [CODE_W-1:0] CODE_RES_4 = 7'h66;
    localparam logic [CODE_W-1:0] CODE_RES_5 = 7'h78;

    // XGMII control characters
    localparam logic [7:0] XG_IDLE  = 8'h07;
    localparam logic [7:0] XG_LPI   = 8'h06;
    localparam logic [7:0] XG_START = 8'hfb;
    localparam logic [7:0] XG_TERM  = 8'hfd;
    localparam logic [7:0] XG_ERROR = 8'hfe;
    localparam logic [7:0] XG_RES_0 = 8'h1c;
    localparam logic [7:0] XG_RES_1 = 8'h3c;
    localparam logic [7:0] XG_RES_2 = 8'h7c;
    localparam logic [7:0] XG_RES_3 = 8'hbc;
    localparam logic [7:0] XG_RES_4 = 8'hdc;
    localparam logic [7:0] XG_RES_5 = 8'hf7;

    // One 8-bit character per XGMII lane, lane 0 in the low byte
    typedef logic [LANES-1:0][7:0] lane_chars_t;

    // Same 64-bit payload seen as raw bytes or as type plus codes
    typedef union packed {
        logic [LANES-1:0][7:0] data;
        struct packed {
            logic [LANES-1:0][CODE_W-1:0] code;
            logic [7:0]                   btype;
        } ctrl;
    } baser_payload_u;

    typedef struct packed {
        logic [HDR_W-1:0] hdr;
        baser_payload_u   payload;
    } baser_block_t;

    // rxc bit i flags lane i as a control character
    typedef struct packed {
        logic [BLOCK_W-1:0] rxd;
        logic [LANES-1:0]   rxc;
    } xgmii_word_t;

endpackage

//--- rtl/baser_rx_dec.sv
`timescale 1ns/1ps

module baser_rx_dec (
    input  logic                    clk,
    input  logic                    rst,
    input  baser_pkg::baser_block_t rx_block,
    output baser_pkg::xgmii_word_t  xgmii_out,
    output logic                    rx_bad_block,
    output logic                    rx_sequence_error
);

    import baser_pkg::*;

    lane_chars_t chars;
    logic [7:0]  lane_err;
    logic        start_seen;
    logic        term_seen;

    // Control codes decoded for every block, used only by control types
    ctrl_code_decoder u_ctrl_code_decoder (
        .codes    (rx_block.payload),
        .chars    (chars),
        .lane_err (lane_err)
    );

    block_mapper u_block_mapper (
        .clk          (clk),
        .rst          (rst),
        .rx_block     (rx_block),
        .chars        (chars),
        .lane_err     (lane_err),
        .xgmii_out    (xgmii_out),
        .rx_bad_block (rx_bad_block),
        .start_seen   (start_seen),
        .term_seen    (term_seen)
    );

    frame_tracker u_frame_tracker (
        .clk               (clk),
        .rst               (rst),
        .start_seen        (start_seen),
        .term_seen         (term_seen),
        .rx_sequence_error (rx_sequence_error)
    );

endmodule

//--- rtl/block_mapper.sv
`timescale 1ns/1ps

module block_mapper (
    input  logic                    clk,
    input  logic                    rst,
    input  baser_pkg::baser_block_t rx_block,
    input  baser_pkg::lane_chars_t  chars,
    input  logic [7:0]              lane_err,
    output baser_pkg::xgmii_word_t  xgmii_out,
    output logic                    rx_bad_block,
    output logic                    start_seen,
    output logic                    term_seen
);

    import baser_pkg::*;

    lane_chars_t      data_bytes;
    lane_chars_t      data_shift;
    lane_chars_t      rxd_next;
    logic [LANES-1:0] rxc_next;
    logic             bad_next;
    logic             term_hit;
    logic [2:0]       term_lane;

    assign data_bytes = rx_block.payload.data;

    // Terminate blocks carry D0 in payload byte 1, so data lanes are one byte down
    assign data_shift = {8'h00, data_bytes[LANES-1:1]};

    always_comb begin
        // Anything not recognised below stays an all-error word
        rxd_next   = {LANES{XG_ERROR}};
        rxc_next   = '1;
        bad_next   = 1'b1;
        start_seen = 1'b0;
        term_seen  = 1'b0;
        term_hit   = 1'b0;
        term_lane  = 3'd0;

        if (rx_block.hdr == SYNC_DATA) begin
            rxd_next = data_bytes;
            rxc_next = '0;
            bad_next = 1'b0;
        end else if (rx_block.hdr == SYNC_CTRL) begin
            case (rx_block.payload.ctrl.btype)
                BT_CTRL: begin
                    rxd_next = chars;
                    rxc_next = '1;
                    bad_next = |lane_err;
                end
                BT_START_0: begin
                    rxd_next    = data_bytes;
                    rxd_next[0] = XG_START;
                    rxc_next    = 8'h01;
                    bad_next    = 1'b0;
                    start_seen  = 1'b1;
                end
                BT_START_4: begin
                    // C0..C3 in the low half, start in lane 4
                    rxd_next   = {data_bytes[7:5], XG_START, chars[3:0]};
                    rxc_next   = 8'h1f;
                    bad_next   = |lane_err[3:0];
                    start_seen = 1'b1;
                end
                BT_TERM_0: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd0;
                end
                BT_TERM_1: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd1;
                end
                BT_TERM_2: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd2;
                end
                BT_TERM_3: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd3;
                end
                BT_TERM_4: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd4;
                end
                BT_TERM_5: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd5;
                end
                BT_TERM_6: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd6;
                end
                BT_TERM_7: begin
                    term_hit  = 1'b1;
                    term_lane = 3'd7;
                end
                default: begin
                    // Ordered sets and unknown types keep the error word
                end
            endcase

            // Data below the terminate lane, decoded controls above it
            if (term_hit) begin
                term_seen = 1'b1;
                bad_next  = 1'b0;
                for (int i = 0; i < LANES; i++) begin
                    if (i < int'(term_lane)) begin
                        rxd_next[i] = data_shift[i];
                        rxc_next[i] = 1'b0;
                    end else if (i == int'(term_lane)) begin
                        rxd_next[i] = XG_TERM;
                        rxc_next[i] = 1'b1;
                    end else begin
                        rxd_next[i] = chars[i];
                        rxc_next[i] = 1'b1;
                        if (lane_err[i]) begin
                            bad_next = 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xgmii_out.rxd <= {LANES{XG_ERROR}};
            xgmii_out.rxc <= '1;
            rx_bad_block  <= 1'b0;
        end else begin
            xgmii_out.rxd <= rxd_next;
            xgmii_out.rxc <= rxc_next;
            rx_bad_block  <= bad_next;
        end
    end

endmodule

//--- rtl/ctrl_code_decoder.sv
`timescale 1ns/1ps

module ctrl_code_decoder (
    input  baser_pkg::baser_payload_u codes,
    output baser_pkg::lane_chars_t    chars,
    output logic [7:0]                lane_err
);

    import baser_pkg::*;

    // Each lane is decoded on its own, no cross-lane dependency
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_err[i] = 1'b0;
            case (codes.ctrl.code[i])
                CODE_IDLE: begin
                    chars[i] = XG_IDLE;
                end
                CODE_LPI: begin
                    chars[i] = XG_LPI;
                end
                CODE_ERROR: begin
                    chars[i] = XG_ERROR;
                end
                CODE_RES_0: begin
                    chars[i] = XG_RES_0;
                end
                CODE_RES_1: begin
                    chars[i] = XG_RES_1;
                end
                CODE_RES_2: begin
                    chars[i] = XG_RES_2;
                end
                CODE_RES_3: begin
                    chars[i] = XG_RES_3;
                end
                CODE_RES_4: begin
                    chars[i] = XG_RES_4;
                end
                CODE_RES_5: begin
                    chars[i] = XG_RES_5;
                end
                default: begin
                    // Unlisted code, replaced by an error character
                    chars[i]    = XG_ERROR;
                    lane_err[i] = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/frame_tracker.sv
`timescale 1ns/1ps

module frame_tracker (
    input  logic clk,
    input  logic rst,
    input  logic start_seen,
    input  logic term_seen,
    output logic rx_sequence_error
);

    typedef enum logic {
        FT_IDLE,
        FT_IN_FRAME
    } frame_state_t;

    frame_state_t state;
    frame_state_t state_next;
    logic         seq_err_next;

    // Start and terminate never arrive together, one block has one type
    always_comb begin
        state_next   = state;
        seq_err_next = 1'b0;
        if (start_seen) begin
            seq_err_next = (state == FT_IN_FRAME);
            state_next   = FT_IN_FRAME;
        end else if (term_seen) begin
            seq_err_next = (state == FT_IDLE);
            state_next   = FT_IDLE;
        end
    end

    // Same edge as the mapper registers, keeps the strobes aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= FT_IDLE;
            rx_sequence_error <= 1'b0;
        end else begin
            state             <= state_next;
            rx_sequence_error <= seq_err_next;
        end
    end

endmodule

//--- tests/baser_rx_dec_checker.sv
`timescale 1ns/1ps

module baser_rx_dec_checker (
    input logic                    clk,
    input logic                    rst,
    input baser_pkg::baser_block_t rx_block,
    input baser_pkg::xgmii_word_t  xgmii_out,
    input logic                    rx_bad_block,
    input logic                    rx_sequence_error
);

    import baser_pkg::*;

    logic bad_header;

    assign bad_header = (rx_block.hdr == 2'b00) || (rx_block.hdr == 2'b11);

    // A data block comes out as eight data lanes
    data_passes: assert property (@(posedge clk) disable iff (rst)
        (rx_block.hdr == SYNC_DATA) |=> ((xgmii_out.rxc == '0) && !rx_bad_block))
        else $error("data block gave control lanes or a bad-block strobe");

    bad_header_flagged: assert property (@(posedge clk) disable iff (rst)
        bad_header |=> rx_bad_block)
        else $error("invalid sync header not flagged as a bad block");

    // First output cycle after reset still shows the cleared strobes
    reset_clears: assert property (@(posedge clk)
        $fell(rst) |-> (!rx_bad_block && !rx_sequence_error))
        else $error("strobes not cleared after reset");

endmodule

bind baser_rx_dec baser_rx_dec_checker u_checker (
    .clk               (clk),
    .rst               (rst),
    .rx_block          (rx_block),
    .xgmii_out         (xgmii_out),
    .rx_bad_block      (rx_bad_block),
    .rx_sequence_error (rx_sequence_error)
);

//--- include/baser_tb_tasks.svh
`ifndef BASER_TB_TASKS_SVH
`define BASER_TB_TASKS_SVH

// Terminate block types indexed by the lane that carries the terminate
localparam logic [7:0][7:0] TERM_TYPES = {BT_TERM_7, BT_TERM_6, BT_TERM_5, BT_TERM_4,
                                          BT_TERM_3, BT_TERM_2, BT_TERM_1, BT_TERM_0};

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
endfunction

function automatic baser_block_t raw_block(input logic [1:0] hdr, input logic [63:0] bits);
    baser_block_t b;
    b.hdr          = hdr;
    b.payload.data = bits;
    return b;
endfunction

function automatic baser_block_t ctrl_block(input logic [7:0] btype, input logic [63:0] bits);
    baser_block_t b;
    b = raw_block(SYNC_CTRL, bits);
    b.payload.ctrl.btype = btype;
    return b;
endfunction

// Writes one code into lanes lo..hi
// An empty range leaves the block alone
function automatic baser_block_t fill_codes(input baser_block_t blk, input int lo, input int hi,
                                            input logic [6:0] code);
    baser_block_t b;
    b = blk;
    for (int i = lo; i <= hi; i++) begin
        b.payload.ctrl.code[i] = code;
    end
    return b;
endfunction

// Bit 8 marks a code that has no XGMII character
function automatic logic [8:0] code_to_char(input logic [6:0] code);
    case (code)
        CODE_IDLE:  return {1'b0, XG_IDLE};
        CODE_LPI:   return {1'b0, XG_LPI};
        CODE_ERROR: return {1'b0, XG_ERROR};
        CODE_RES_0: return {1'b0, XG_RES_0};
        CODE_RES_1: return {1'b0, XG_RES_1};
        CODE_RES_2: return {1'b0, XG_RES_2};
        CODE_RES_3: return {1'b0, XG_RES_3};
        CODE_RES_4: return {1'b0, XG_RES_4};
        CODE_RES_5: return {1'b0, XG_RES_5};
        default:    return {1'b1, XG_ERROR};
    endcase
endfunction

// Reference model for one block
// It also steps the frame state
task automatic predict_block(input baser_block_t blk);
    logic [8:0] dec [8];
    logic [7:0] bt;
    int         k;
    bt = blk.payload.ctrl.btype;
    k  = -1;
    for (int i = 0; i < 8; i++) begin
        dec[i] = code_to_char(blk.payload.ctrl.code[i]);
        if (bt == TERM_TYPES[i]) begin
            k = i;
        end
    end
    exp_rxd = {8{XG_ERROR}};
    exp_rxc = 8'hff;
    exp_bad = 1'b1;
    exp_seq = 1'b0;
    if (blk.hdr == SYNC_DATA) begin
        exp_rxd = blk.payload.data;
        exp_rxc = 8'h00;
        exp_bad = 1'b0;
    end else if (blk.hdr == SYNC_CTRL) begin
        if (bt == BT_CTRL) begin
            exp_bad = 1'b0;
            for (int i = 0; i < 8; i++) begin
                exp_rxd[8*i +: 8] = dec[i][7:0];
                exp_bad           = exp_bad | dec[i][8];
            end
        end else if (bt == BT_START_0 || bt == BT_START_4) begin
            exp_seq        = model_in_frame;
            model_in_frame = 1'b1;
            exp_bad        = 1'b0;
            exp_rxc        = (bt == BT_START_0) ? 8'h01 : 8'h1f;
            for (int i = 0; i < 8; i++) begin
                if ((bt == BT_START_0 && i == 0) || (bt == BT_START_4 && i == 4)) begin
                    exp_rxd[8*i +: 8] = XG_START;
                end else if (bt == BT_START_4 && i < 4) begin
                    exp_rxd[8*i +: 8] = dec[i][7:0];
                    exp_bad           = exp_bad | dec[i][8];
                end else begin
                    exp_rxd[8*i +: 8] = blk.payload.data[i];
                end
            end
        end else if (k >= 0) begin
            exp_seq        = !model_in_frame;
            model_in_frame = 1'b0;
            exp_bad        = 1'b0;
            for (int i = 0; i < 8; i++) begin
                if (i < k) begin
                    exp_rxd[8*i +: 8] = blk.payload.data[i+1];
                    exp_rxc[i]        = 1'b0;
                end else if (i == k) begin
                    exp_rxd[8*i +: 8] = XG_TERM;
                end else begin
                    exp_rxd[8*i +: 8] = dec[i][7:0];
                    exp_bad           = exp_bad | dec[i][8];
                end
            end
        end
    end
endtask

// Results appear one cycle late, so each call checks the block driven before it
task automatic drive_block(input baser_block_t blk);
    @(posedge clk);
    rx_block <= blk;
    @(negedge clk);
    check_value("xgmii_out.rxd", xgmii_out.rxd, exp_rxd);
    check_value("xgmii_out.rxc", 64'(xgmii_out.rxc), 64'(exp_rxc));
    check_value("rx_bad_block", 64'(rx_bad_block), 64'(exp_bad));
    check_value("rx_sequence_error", 64'(rx_sequence_error), 64'(exp_seq));
    predict_block(blk);
endtask

task automatic test_reset_state();
    check_value("xgmii_out.rxd", xgmii_out.rxd, {8{XG_ERROR}});
    check_value("xgmii_out.rxc", 64'(xgmii_out.rxc), 64'hff);
    check_value("rx_bad_block", 64'(rx_bad_block), 64'h0);
    check_value("rx_sequence_error", 64'(rx_sequence_error), 64'h0);
endtask

task automatic test_data_pass();
    repeat (16) begin
        drive_block(raw_block(SYNC_DATA, rand64()));
    end
endtask

task automatic test_ctrl_codes();
    baser_block_t blk;
    drive_block(ctrl_block(BT_CTRL, 64'h0));
    drive_block(fill_codes(ctrl_block(BT_CTRL, 64'h0), 0, 7, CODE_LPI));
    blk = ctrl_block(BT_CTRL, 64'h0);
    blk = fill_codes(blk, 0, 0, CODE_RES_0);
    blk = fill_codes(blk, 1, 1, CODE_RES_1);
    blk = fill_codes(blk, 2, 2, CODE_RES_2);
    blk = fill_codes(blk, 3, 3, CODE_RES_3);
    blk = fill_codes(blk, 4, 4, CODE_RES_4);
    blk = fill_codes(blk, 5, 5, CODE_RES_5);
    blk = fill_codes(blk, 6, 6, CODE_ERROR);
    blk = fill_codes(blk, 7, 7, CODE_LPI);
    drive_block(blk);
    // Code 01 is not listed
    drive_block(fill_codes(ctrl_block(BT_CTRL, 64'h0), 3, 3, 7'h01));
endtask

task automatic test_start_term();
    for (int k = 0; k < 8; k++) begin
        if (k % 2 == 0) begin
            drive_block(ctrl_block(BT_START_0, rand64()));
        end else begin
            drive_block(fill_codes(ctrl_block(BT_START_4, rand64()), 0, 3, CODE_IDLE));
        end
        drive_block(raw_block(SYNC_DATA, rand64()));
        drive_block(fill_codes(ctrl_block(TERM_TYPES[k], rand64()), k + 1, 7, CODE_IDLE));
    end
endtask

task automatic test_bad_blocks();
    baser_block_t blk;
    drive_block(raw_block(2'b00, rand64()));
    drive_block(raw_block(2'b11, rand64()));
    drive_block(ctrl_block(8'h5a, rand64()));
    drive_block(ctrl_block(8'h4b, rand64()));
    // Unlisted codes in the control lanes of a start and a terminate block
    blk = fill_codes(ctrl_block(BT_START_4, rand64()), 0, 3, CODE_IDLE);
    drive_block(fill_codes(blk, 1, 1, 7'h01));
    blk = fill_codes(ctrl_block(BT_TERM_3, rand64()), 4, 7, CODE_IDLE);
    drive_block(fill_codes(blk, 6, 6, 7'h01));
endtask

task automatic test_sequence_errors();
    drive_block(ctrl_block(BT_START_0, rand64()));
    drive_block(ctrl_block(BT_START_0, rand64()));
    drive_block(ctrl_block(BT_TERM_7, rand64()));
    drive_block(fill_codes(ctrl_block(BT_TERM_0, rand64()), 1, 7, CODE_IDLE));
    drive_block(ctrl_block(BT_CTRL, 64'h0));
endtask

`endif

//--- tests/tb_baser_rx_dec.sv
`timescale 1ns/1ps

module tb_baser_rx_dec;

    import baser_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 2;
    // Blocks per test in run order and the closing flush block
    localparam int TEST_BLOCKS  = 16 + 4 + 24 + 6 + 5 + 1;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_BLOCKS + 20) * CLK_PERIOD;

    logic         clk;
    logic         rst;
    baser_block_t rx_block;
    xgmii_word_t  xgmii_out;
    logic         rx_bad_block;
    logic         rx_sequence_error;

    // Expected outputs for the block currently held on rx_block
    logic [63:0]  exp_rxd;
    logic [7:0]   exp_rxc;
    logic         exp_bad;
    logic         exp_seq;
    logic         model_in_frame;

    int           check_count;
    int           error_count;

    `include "baser_tb_tasks.svh"

    baser_rx_dec DUT (
        .clk               (clk),
        .rst               (rst),
        .rx_block          (rx_block),
        .xgmii_out         (xgmii_out),
        .rx_bad_block      (rx_bad_block),
        .rx_sequence_error (rx_sequence_error)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h3f21));
        check_count    = 0;
        error_count    = 0;
        model_in_frame = 1'b0;
        rst            = 1'b1;
        rx_block       = ctrl_block(BT_CTRL, 64'h0);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset_state();

        // Idle block held through reset is the first one sampled
        predict_block(rx_block);

        test_data_pass();
        test_ctrl_codes();
        test_start_term();
        test_bad_blocks();
        test_sequence_errors();

        // One more block pushes the last result out
        drive_block(ctrl_block(BT_CTRL, 64'h0));

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
